// ==== logic/lane_pkg.sv ====
package lane_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////
	localparam int DATA_W  = 32;
	localparam int INDEX_W = 6;
	localparam int ISSUE_W = 5;
	localparam int ADDR_W  = 16;

	typedef logic [DATA_W-1:0]  data_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [ISSUE_W-1:0] issue_no_t;	// Wraps, age is newest minus this
	typedef logic [ADDR_W-1:0]  addr_t;

	//////////////////////////////
	// Opcode fields
	//////////////////////////////
	typedef logic [1:0] op_type_t;
	typedef logic [1:0] op_class_t;

	// Unit selector values, 1 and 2 are reserved
	localparam op_type_t OP_MAC  = 2'd0;
	localparam op_type_t OP_LDST = 2'd3;

	// Bit positions inside op_class
	localparam int CLASS_ODD_BIT   = 0;	// Port select
	localparam int CLASS_STORE_BIT = 1;	// Store when set

	//////////////////////////////
	// Command
	//////////////////////////////
	typedef struct packed {
		op_type_t  op_type;
		op_class_t op_class;
		index_t    dst;
		issue_no_t issue_no;
	} command_t;

	// Multiply-add pipeline depth
	localparam int MAC_DEPTH_DEF = 4;

endpackage

// ==== logic/wb_if.sv ====
`timescale 1ns/1ps

// Held result of one unit towards the writeback selector
interface wb_if;
	import lane_pkg::*;

	logic      valid;
	index_t    dst;
	data_t     data;
	issue_no_t issue_no;
	logic      take;	// Result leaves the unit in this cycle

	modport src (
		output valid,
		output dst,
		output data,
		output issue_no,
		input  take
	);

	modport sel (
		input  valid,
		input  dst,
		input  data,
		input  issue_no,
		output take
	);

endinterface

// ==== logic/mac_unit.sv ====
`timescale 1ns/1ps

module mac_unit #(
	parameter int depth = 4
)(
	input                       clock,
	input                       rst,
	input                       start,
	input  lane_pkg::index_t    dst,
	input  lane_pkg::issue_no_t issue_no,
	input  lane_pkg::data_t     a,
	input  lane_pkg::data_t     b,
	input  lane_pkg::data_t     c,
	output logic                stalled,
	wb_if.src                   wb
);
	import lane_pkg::*;

	logic [depth-1:0] vld;
	data_t            res_q [depth];
	index_t           dst_q [depth];
	issue_no_t        iss_q [depth];
	logic             advance;

	// Last stage doubles as the hold slot
	assign stalled = vld[depth-1] && !wb.take;
	assign advance = !stalled;

	//////////////////////////////
	// Pipeline
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (rst) begin
			vld <= '0;
		end else if (advance) begin
			vld[0] <= start;
			for (int i = 1; i < depth; i++) begin
				vld[i] <= vld[i-1];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			res_q[0] <= a * b + c;	// Modulo 2^32
			dst_q[0] <= dst;
			iss_q[0] <= issue_no;
			for (int i = 1; i < depth; i++) begin
				res_q[i] <= res_q[i-1];
				dst_q[i] <= dst_q[i-1];
				iss_q[i] <= iss_q[i-1];
			end
		end
	end

	//////////////////////////////
	// Writeback side
	//////////////////////////////
	assign wb.valid    = vld[depth-1];
	assign wb.dst      = dst_q[depth-1];
	assign wb.data     = res_q[depth-1];
	assign wb.issue_no = iss_q[depth-1];

	// A frozen pipeline cannot take a new command
	a_no_start_stalled: assert property (
		@(posedge clock) disable iff (rst)
		start |-> !stalled
	);

endmodule

// ==== logic/ldst_unit.sv ====
`timescale 1ns/1ps

module ldst_unit (
	input                       clock,
	input                       rst,
	input                       start,
	input                       store,
	input  lane_pkg::index_t    dst,
	input  lane_pkg::issue_no_t issue_no,
	input  lane_pkg::addr_t     addr,
	input  lane_pkg::data_t     wdata,
	input                       mem_grant,
	input                       mem_ready,
	input  lane_pkg::data_t     mem_rdata,
	output logic                idle,
	output logic                mem_req,
	output logic                mem_we,
	output lane_pkg::addr_t     mem_addr,
	output lane_pkg::data_t     mem_wdata,
	wb_if.src                   wb
);
	import lane_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		WAIT,
		HOLD
	} state_t;

	state_t    state;
	state_t    state_nxt;
	logic      store_q;
	index_t    dst_q;
	issue_no_t iss_q;
	addr_t     addr_q;
	data_t     data_q;	// Store data, then load result
	logic      load_done;

	//////////////////////////////
	// State machine
	//////////////////////////////
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (start) begin
					state_nxt = REQ;
				end
			end
			REQ: begin
				if (mem_grant && mem_ready) begin
					state_nxt = HOLD;	// Same-cycle answer
				end else if (mem_grant) begin
					state_nxt = WAIT;
				end
			end
			WAIT: begin
				if (mem_ready) begin
					state_nxt = HOLD;
				end
			end
			HOLD: begin
				if (wb.take) begin
					state_nxt = IDLE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	assign load_done = !store_q && mem_ready &&
		((state == WAIT) || (state == REQ && mem_grant));

	// Command latch and load capture
	always_ff @(posedge clock) begin
		if (start && state == IDLE) begin
			store_q <= store;
			dst_q   <= dst;
			iss_q   <= issue_no;
			addr_q  <= addr;
			data_q  <= wdata;
		end else if (load_done) begin
			data_q  <= mem_rdata;
		end
	end

	assign idle      = (state == IDLE);
	assign mem_req   = (state == REQ);
	assign mem_we    = store_q;
	assign mem_addr  = addr_q;
	assign mem_wdata = data_q;

	assign wb.valid    = (state == HOLD);
	assign wb.dst      = dst_q;
	assign wb.data     = data_q;
	assign wb.issue_no = iss_q;

	a_req_hold: assert property (
		@(posedge clock) disable iff (rst)
		mem_req && !mem_grant |=> mem_req && $stable(mem_addr)
	);

	a_start_idle: assert property (
		@(posedge clock) disable iff (rst)
		start |-> idle
	);

endmodule

// ==== logic/wb_select.sv ====
`timescale 1ns/1ps

module wb_select (
	input                             clock,
	input                             rst,
	input                             issue_strobe,
	input  lane_pkg::issue_no_t       issue_no,
	wb_if.sel                         mac_wb,
	wb_if.sel                         even_wb,
	wb_if.sel                         odd_wb,
	output logic                      wb_valid,
	output lane_pkg::index_t          wb_dst,
	output lane_pkg::data_t           wb_data,
	output lane_pkg::issue_no_t       wb_issue_no
);
	import lane_pkg::*;

	issue_no_t newest;
	issue_no_t age_mac;
	issue_no_t age_even;
	issue_no_t age_odd;
	logic      pick_mac;
	logic      pick_even;
	logic      pick_odd;

	always_ff @(posedge clock) begin
		if (rst) begin
			newest <= '0;
		end else if (issue_strobe) begin
			newest <= issue_no;
		end
	end

	//////////////////////////////
	// Oldest first
	//////////////////////////////
	assign age_mac  = newest - mac_wb.issue_no;	// Wrapping distance
	assign age_even = newest - even_wb.issue_no;
	assign age_odd  = newest - odd_wb.issue_no;

	// Ties go to mac, then even
	assign pick_mac = mac_wb.valid &&
		(!even_wb.valid || age_mac >= age_even) &&
		(!odd_wb.valid || age_mac >= age_odd);
	assign pick_even = even_wb.valid && !pick_mac &&
		(!odd_wb.valid || age_even >= age_odd);
	assign pick_odd = odd_wb.valid && !pick_mac && !pick_even;

	assign mac_wb.take  = pick_mac;
	assign even_wb.take = pick_even;
	assign odd_wb.take  = pick_odd;

	// Register file write, one cycle after the take
	always_ff @(posedge clock) begin
		if (rst) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= pick_mac || pick_even || pick_odd;
		end
	end

	always_ff @(posedge clock) begin
		if (pick_mac) begin
			wb_dst      <= mac_wb.dst;
			wb_data     <= mac_wb.data;
			wb_issue_no <= mac_wb.issue_no;
		end else if (pick_even) begin
			wb_dst      <= even_wb.dst;
			wb_data     <= even_wb.data;
			wb_issue_no <= even_wb.issue_no;
		end else if (pick_odd) begin
			wb_dst      <= odd_wb.dst;
			wb_data     <= odd_wb.data;
			wb_issue_no <= odd_wb.issue_no;
		end
	end

	a_one_take: assert property (
		@(posedge clock) disable iff (rst)
		$onehot0({mac_wb.take, even_wb.take, odd_wb.take})
	);

endmodule

// ==== logic/exec_lane.sv ====
`timescale 1ns/1ps

module exec_lane #(
	parameter int mac_depth = lane_pkg::MAC_DEPTH_DEF
)(
	input                         clock,
	input                         rst,
	input                         req,
	input  lane_pkg::command_t    cmd,
	input  lane_pkg::data_t       src1,
	input  lane_pkg::data_t       src2,
	input  lane_pkg::data_t       src3,
	output logic                  busy,
	// Even memory port
	output logic                  mem_req_even,
	output logic                  mem_we_even,
	output lane_pkg::addr_t       mem_addr_even,
	output lane_pkg::data_t       mem_wdata_even,
	input                         mem_grant_even,
	input                         mem_ready_even,
	input  lane_pkg::data_t       mem_rdata_even,
	// Odd memory port
	output logic                  mem_req_odd,
	output logic                  mem_we_odd,
	output lane_pkg::addr_t       mem_addr_odd,
	output lane_pkg::data_t       mem_wdata_odd,
	input                         mem_grant_odd,
	input                         mem_ready_odd,
	input  lane_pkg::data_t       mem_rdata_odd,
	// Register file write
	output logic                  wb_valid,
	output lane_pkg::index_t      wb_dst,
	output lane_pkg::data_t       wb_data,
	output lane_pkg::issue_no_t   wb_issue_no
);
	import lane_pkg::*;

	logic  mac_start;
	logic  ldst_cmd;
	logic  even_start;
	logic  odd_start;
	logic  mac_stalled;
	logic  even_idle;
	logic  odd_idle;
	addr_t ldst_addr;

	wb_if mac_wb ();
	wb_if even_wb ();
	wb_if odd_wb ();

	//////////////////////////////
	// Decode
	//////////////////////////////
	assign mac_start  = req && (cmd.op_type == OP_MAC);
	assign ldst_cmd   = req && (cmd.op_type == OP_LDST);	// Reserved types fall through
	assign even_start = ldst_cmd && !cmd.op_class[CLASS_ODD_BIT];
	assign odd_start  = ldst_cmd && cmd.op_class[CLASS_ODD_BIT];
	assign ldst_addr  = src1[ADDR_W-1:0];

	assign busy = req || mac_stalled || !even_idle || !odd_idle;

	mac_unit #(
		.depth    (mac_depth)
	) mac_i (
		.clock    (clock),
		.rst      (rst),
		.start    (mac_start),
		.dst      (cmd.dst),
		.issue_no (cmd.issue_no),
		.a        (src1),
		.b        (src2),
		.c        (src3),
		.stalled  (mac_stalled),
		.wb       (mac_wb.src)
	);

	ldst_unit ldst_even (
		.clock     (clock),
		.rst       (rst),
		.start     (even_start),
		.store     (cmd.op_class[CLASS_STORE_BIT]),
		.dst       (cmd.dst),
		.issue_no  (cmd.issue_no),
		.addr      (ldst_addr),
		.wdata     (src2),
		.mem_grant (mem_grant_even),
		.mem_ready (mem_ready_even),
		.mem_rdata (mem_rdata_even),
		.idle      (even_idle),
		.mem_req   (mem_req_even),
		.mem_we    (mem_we_even),
		.mem_addr  (mem_addr_even),
		.mem_wdata (mem_wdata_even),
		.wb        (even_wb.src)
	);

	ldst_unit ldst_odd (
		.clock     (clock),
		.rst       (rst),
		.start     (odd_start),
		.store     (cmd.op_class[CLASS_STORE_BIT]),
		.dst       (cmd.dst),
		.issue_no  (cmd.issue_no),
		.addr      (ldst_addr),
		.wdata     (src2),
		.mem_grant (mem_grant_odd),
		.mem_ready (mem_ready_odd),
		.mem_rdata (mem_rdata_odd),
		.idle      (odd_idle),
		.mem_req   (mem_req_odd),
		.mem_we    (mem_we_odd),
		.mem_addr  (mem_addr_odd),
		.mem_wdata (mem_wdata_odd),
		.wb        (odd_wb.src)
	);

	wb_select wb_select_i (
		.clock        (clock),
		.rst          (rst),
		.issue_strobe (req),
		.issue_no     (cmd.issue_no),
		.mac_wb       (mac_wb.sel),
		.even_wb      (even_wb.sel),
		.odd_wb       (odd_wb.sel),
		.wb_valid     (wb_valid),
		.wb_dst       (wb_dst),
		.wb_data      (wb_data),
		.wb_issue_no  (wb_issue_no)
	);

endmodule

// ==== tests/exec_lane_tb.sv ====
`timescale 1ns/1ps

module exec_lane_tb;
	import lane_pkg::*;

	localparam int MAX_CASES = 64;
	localparam int MAX_ACC   = 64;
	localparam int SLOTS     = 32;	// One per issue number
	localparam int MAC_LAT   = 4;	// Default multiply-add depth

	logic       clock;
	logic       rst;
	logic       req;
	command_t   cmd;
	data_t      src1;
	data_t      src2;
	data_t      src3;
	logic       busy;
	logic [1:0] mem_grant;
	logic [1:0] mem_ready;
	data_t      mem_rdata [2];
	logic       mem_req_even;
	logic       mem_we_even;
	addr_t      mem_addr_even;
	data_t      mem_wdata_even;
	logic       mem_req_odd;
	logic       mem_we_odd;
	addr_t      mem_addr_odd;
	data_t      mem_wdata_odd;
	logic       wb_valid;
	index_t     wb_dst;
	data_t      wb_data;
	issue_no_t  wb_issue_no;

	// Port views indexed by op_class bit 0
	logic [1:0] port_req;
	logic [1:0] port_we;
	addr_t      port_addr [2];
	data_t      port_wdata [2];

	// Cases from file
	string c_name [MAX_CASES];
	int    c_type [MAX_CASES];
	int    c_class [MAX_CASES];
	int    c_dst [MAX_CASES];
	data_t c_src1 [MAX_CASES];
	data_t c_src2 [MAX_CASES];
	data_t c_src3 [MAX_CASES];
	data_t c_exp [MAX_CASES];

	// Scoreboard per issue number
	logic   pending [SLOTS];
	index_t exp_dst [SLOTS];
	data_t  exp_data [SLOTS];
	string  slot_name [SLOTS];
	int     slot_seq [SLOTS];
	logic   slot_mac [SLOTS];
	logic   hold_known [SLOTS];
	int     hold_cycle [SLOTS];	// First cycle the result sits in HOLD

	// Expected accesses per port, in order
	addr_t acc_addr [2][MAX_ACC];
	logic  acc_we [2][MAX_ACC];
	data_t acc_wdata [2][MAX_ACC];
	int    acc_issue [2][MAX_ACC];
	string acc_name [2][MAX_ACC];
	int    push_n [2];
	int    pop_n [2];

	int    grant_dly [2][MAX_ACC];
	int    ready_dly [2][MAX_ACC];
	data_t mem_words [2][65536];

	int   cyc;
	int   n_cases;
	logic cases_loaded;
	int   outstanding;
	int   last_mac_seq;

	assign port_req      = {mem_req_odd, mem_req_even};
	assign port_we       = {mem_we_odd, mem_we_even};
	assign port_addr[0]  = mem_addr_even;
	assign port_addr[1]  = mem_addr_odd;
	assign port_wdata[0] = mem_wdata_even;
	assign port_wdata[1] = mem_wdata_odd;

	exec_lane exec_lane_i (
		.clock          (clock),
		.rst            (rst),
		.req            (req),
		.cmd            (cmd),
		.src1           (src1),
		.src2           (src2),
		.src3           (src3),
		.busy           (busy),
		.mem_req_even   (mem_req_even),
		.mem_we_even    (mem_we_even),
		.mem_addr_even  (mem_addr_even),
		.mem_wdata_even (mem_wdata_even),
		.mem_grant_even (mem_grant[0]),
		.mem_ready_even (mem_ready[0]),
		.mem_rdata_even (mem_rdata[0]),
		.mem_req_odd    (mem_req_odd),
		.mem_we_odd     (mem_we_odd),
		.mem_addr_odd   (mem_addr_odd),
		.mem_wdata_odd  (mem_wdata_odd),
		.mem_grant_odd  (mem_grant[1]),
		.mem_ready_odd  (mem_ready[1]),
		.mem_rdata_odd  (mem_rdata[1]),
		.wb_valid       (wb_valid),
		.wb_dst         (wb_dst),
		.wb_data        (wb_data),
		.wb_issue_no    (wb_issue_no)
	);

	always #20 clock = ~clock;

	always @(posedge clock) cyc <= cyc + 1;

	//////////////////////////////
	// Checks and scoreboard
	//////////////////////////////
	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	task automatic issue_case(input int k, input int seq);
		issue_no_t iss;
		int        p;
		int        slot;
		iss          = issue_no_t'(seq);	// Wraps at 32
		cmd.op_type  = op_type_t'(c_type[k]);
		cmd.op_class = op_class_t'(c_class[k]);
		cmd.dst      = index_t'(c_dst[k]);
		cmd.issue_no = iss;
		src1         = c_src1[k];
		src2         = c_src2[k];
		src3         = c_src3[k];
		req          = 1'b1;
		if (c_type[k] == OP_MAC || c_type[k] == OP_LDST) begin
			check_value({c_name[k], "_slot_free"}, 0, pending[iss]);
			pending[iss]    = 1'b1;
			exp_dst[iss]    = index_t'(c_dst[k]);
			exp_data[iss]   = c_exp[k];
			slot_name[iss]  = c_name[k];
			slot_seq[iss]   = seq;
			slot_mac[iss]   = (c_type[k] == OP_MAC);
			hold_known[iss] = (c_type[k] == OP_MAC);	// Mac latency is fixed
			hold_cycle[iss] = cyc + MAC_LAT;
			outstanding++;
		end
		if (c_type[k] == OP_LDST) begin
			p    = c_class[k] & 1;
			slot = push_n[p] % MAX_ACC;
			acc_addr[p][slot]  = c_src1[k][15:0];
			acc_we[p][slot]    = (c_class[k] >> 1) & 1;
			acc_wdata[p][slot] = c_src2[k];
			acc_issue[p][slot] = iss;
			acc_name[p][slot]  = c_name[k];
			push_n[p]++;
		end
	endtask

	task automatic record_writeback();
		int x;
		int y;
		x = int'(wb_issue_no);
		check_value("unexpected_writeback", 1, pending[x]);
		check_value({slot_name[x], "_dst"}, exp_dst[x], wb_dst);
		check_value({slot_name[x], "_data"}, exp_data[x], wb_data);
		// Taken one cycle before wb_valid
		for (y = 0; y < SLOTS; y++) begin
			if (pending[y] && hold_known[y] && hold_cycle[y] < cyc &&
					slot_seq[y] < slot_seq[x]) begin
				check_value({slot_name[x], "_order"}, y, x);
			end
		end
		if (slot_mac[x]) begin
			check_value({slot_name[x], "_mac_order"}, 1, slot_seq[x] > last_mac_seq);
			last_mac_seq = slot_seq[x];
		end
		pending[x] = 1'b0;
		outstanding--;
	endtask

	always @(negedge clock) begin
		if (!rst && wb_valid) begin
			record_writeback();
		end
	end

	//////////////////////////////
	// Memory models
	//////////////////////////////
	task automatic serve_memory(input int p);
		int    n;
		int    slot;
		addr_t a;
		n = 0;
		forever begin
			@(negedge clock);
			if (!rst && port_req[p]) begin
				repeat (grant_dly[p][n % MAX_ACC]) @(negedge clock);
				if (pop_n[p] >= push_n[p]) begin
					$display("Memory port %0d got a request that no command sent to it", p);
					$display("Simulation FAILED");
					$fatal(1);
				end
				slot = pop_n[p] % MAX_ACC;
				a    = port_addr[p];
				check_value({acc_name[p][slot], "_req_held"}, 1, port_req[p]);
				check_value({acc_name[p][slot], "_addr"}, acc_addr[p][slot], a);
				check_value({acc_name[p][slot], "_we"}, acc_we[p][slot], port_we[p]);
				if (port_we[p]) begin
					check_value({acc_name[p][slot], "_wdata"}, acc_wdata[p][slot],
						port_wdata[p]);
					mem_words[p][a] = port_wdata[p];
				end
				mem_grant[p] = 1'b1;
				@(negedge clock);
				mem_grant[p] = 1'b0;
				repeat (ready_dly[p][n % MAX_ACC] - 1) @(negedge clock);
				mem_ready[p] = 1'b1;
				mem_rdata[p] = mem_words[p][a];
				hold_cycle[acc_issue[p][slot]] = cyc + 1;
				hold_known[acc_issue[p][slot]] = 1'b1;
				@(negedge clock);
				mem_ready[p] = 1'b0;
				mem_rdata[p] = '0;
				pop_n[p]++;
				n++;
			end
		end
	endtask

	initial serve_memory(0);
	initial serve_memory(1);

	// Watchdog, 200 cycles per case
	initial begin
		wait (cases_loaded == 1'b1);
		repeat (n_cases * 200) @(posedge clock);
		$display("Timeout: writebacks did not complete");
		$display("Simulation FAILED");
		$fatal(1);
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		int    fd;
		int    r;
		int    i;
		int    j;
		int    k;
		int    seq;
		int    seed_val;
		string line;
		string name;
		int    ty;
		int    cl;
		int    ds;
		data_t s1;
		data_t s2;
		data_t s3;
		data_t ex;

		clock = 1'b0;
		rst = 1'b1;
		req = 1'b0;
		cmd = '0;
		src1 = '0;
		src2 = '0;
		src3 = '0;
		mem_grant = '0;
		mem_ready = '0;
		mem_rdata[0] = '0;
		mem_rdata[1] = '0;
		cyc = 0;
		cases_loaded = 1'b0;
		outstanding = 0;
		last_mac_seq = -1;
		seed_val = $urandom(32'h77b3);

		for (i = 0; i < SLOTS; i++) begin
			pending[i] = 1'b0;
			hold_known[i] = 1'b0;
		end
		for (i = 0; i < 2; i++) begin
			push_n[i] = 0;
			pop_n[i] = 0;
			for (j = 0; j < MAX_ACC; j++) begin
				grant_dly[i][j] = $urandom % 4;
				ready_dly[i][j] = 1 + $urandom % 4;
			end
			for (j = 0; j < 65536; j++) begin
				mem_words[i][j] = {j[15:0] ^ (i == 1 ? 16'h3c3c : 16'hc35a), j[15:0]};
			end
		end

		fd = $fopen("tests/exec_lane_cases.txt", "r");
		if (fd == 0) begin
			$display("Cannot open tests/exec_lane_cases.txt");
			$display("Simulation FAILED");
			$fatal(1);
		end
		n_cases = 0;
		while (!$feof(fd)) begin
			line = "";
			r = $fgets(line, fd);
			if (r > 0 && line.getc(0) != "#") begin
				r = $sscanf(line, "%s %d %d %d %h %h %h %h", name, ty, cl, ds, s1, s2, s3, ex);
				if (r == 8 && n_cases < MAX_CASES) begin
					c_name[n_cases] = name;
					c_type[n_cases] = ty;
					c_class[n_cases] = cl;
					c_dst[n_cases] = ds;
					c_src1[n_cases] = s1;
					c_src2[n_cases] = s2;
					c_src3[n_cases] = s3;
					c_exp[n_cases] = ex;
					n_cases++;
				end else if (r > 0) begin
					$display("Bad or surplus line in case file: %s", line);
					$display("Simulation FAILED");
					$fatal(1);
				end
			end
		end
		$fclose(fd);
		if (n_cases == 0) begin
			$display("Case file holds no cases");
			$display("Simulation FAILED");
			$fatal(1);
		end
		cases_loaded = 1'b1;

		repeat (3) @(negedge clock);
		rst = 1'b0;
		@(negedge clock);
		check_value("reset_busy", 0, busy);
		check_value("reset_wb_valid", 0, wb_valid);
		check_value("reset_mem_req_even", 0, mem_req_even);
		check_value("reset_mem_req_odd", 0, mem_req_odd);

		// busy counts our own req, so look once it has dropped
		k = 0;
		seq = 0;
		while (k < n_cases) begin
			@(negedge clock);
			req = 1'b0;
			#1;
			if (!busy) begin
				issue_case(k, seq);
				k++;
				seq++;
			end
		end
		@(negedge clock);
		req = 1'b0;

		wait (outstanding == 0);
		repeat (20) @(negedge clock);	// Catch late or duplicate writebacks
		check_value("drained_busy", 0, busy);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== verilog.f ====
logic/lane_pkg.sv
logic/wb_if.sv
logic/mac_unit.sv
logic/ldst_unit.sv
logic/wb_select.sv
logic/exec_lane.sv
tests/exec_lane_tb.sv

// ==== tests/exec_lane_cases.txt ====
# name op_type op_class dst src1 src2 src3 expected (op_type, op_class, dst decimal; rest hex)
# op_type 0 multiply-add, 3 load/store, 1 and 2 reserved; op_class bit 0 odd port, bit 1 store
mac_small   0 0 1  00000003 00000005 00000007 00000016
mac_zero    0 0 2  00000000 12345678 0000abcd 0000abcd
mac_one     0 0 3  00000001 deadbeef 00000001 deadbef0
mac_wrap    0 0 4  ffffffff 00000002 00000003 00000001
mac_sq      0 0 5  00010000 00010000 00000005 00000005
mac_neg     0 0 6  ffffffff ffffffff 00000000 00000001
mac_mid     0 0 7  00001000 00000100 00000011 00100011
mac_mix     0 0 8  0000000a 0000000b 00000064 000000d2
st_even_a   3 2 9  00000040 cafef00d 00000000 cafef00d
ld_even_a   3 0 10 00000040 00000000 00000000 cafef00d
st_odd_a    3 3 11 00000040 0badc0de 00000000 0badc0de
ld_even_b   3 0 12 00000040 00000000 00000000 cafef00d
ld_odd_a    3 1 13 00000040 00000000 00000000 0badc0de
st_even_hi  3 2 14 00030080 11223344 00000000 11223344
ld_even_hi  3 0 15 00000080 00000000 00000000 11223344
rsv_one     1 0 16 00000001 00000002 00000003 00000000
rsv_two     2 1 17 00000004 00000005 00000006 00000000
mac_a       0 0 20 00000002 00000003 00000004 0000000a
st_odd_b    3 3 21 0000ffff 89abcdef 00000000 89abcdef
mac_b       0 0 22 00000007 00000007 00000001 00000032
ld_odd_b    3 1 23 0000ffff 00000000 00000000 89abcdef
mac_c       0 0 24 00000100 00000100 00000100 00010100
st_odd_c    3 3 25 00000040 55aa55aa 00000000 55aa55aa
ld_odd_c    3 1 26 00000040 00000000 00000000 55aa55aa
ld_even_c   3 0 27 00000040 00000000 00000000 cafef00d
mac_d       0 0 30 00000011 00000011 00000000 00000121
mac_e       0 0 31 00000020 00000002 00000001 00000041
mac_f       0 0 32 80000000 00000002 00000007 00000007
mac_g       0 0 33 7fffffff 00000001 00000001 80000000
st_even_d   3 2 34 00001234 a5a5a5a5 00000000 a5a5a5a5
mac_h       0 0 35 00000003 00000003 00000003 0000000c
ld_even_d   3 0 36 00001234 00000000 00000000 a5a5a5a5
rsv_three   1 3 37 00000009 00000009 00000009 00000000
mac_i       0 0 38 000000ff 000000ff 00000001 0000fe02
ld_odd_d    3 1 39 0000ffff 00000000 00000000 89abcdef
mac_j       0 0 40 00000002 00000002 fffffffe 00000002
st_even_e   3 2 41 00000040 01020304 00000000 01020304
mac_k       0 0 42 00000005 00000006 00000007 00000025
ld_even_e   3 0 43 00000040 00000000 00000000 01020304
